// File: rtl/bdd_pkg.sv
`default_nettype none

package bdd_pkg;

	// Bit 0 is the negation flag, bits 15..1 address the node
	typedef logic [15:0] edge_t;

	typedef logic [7:0] var_t; // Smaller number sits nearer the root

	typedef enum logic
	{
		op_and,
		op_or
	} apply_op_t;

	// Node 0 is the constant true terminal
	localparam edge_t edge_true = 16'h0000;
	localparam edge_t edge_false = 16'h0001; // Negated terminal

	// Same node, opposite polarity
	function automatic logic is_complement(edge_t a, edge_t b);
		return (a ^ b) == edge_t'(1);
	endfunction

endpackage

`default_nettype wire

// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;
	import bdd_pkg::*;

	localparam int edge_w = $bits(edge_t);
	localparam int var_w = $bits(var_t);

	typedef logic [edge_w-2:0] node_addr_t; // Edge without its negation bit

	// Node word is {var, high child, low child}
	typedef logic [var_w+2*edge_w-1:0] node_word_t;

	typedef enum logic [2:0] {idle, send_f, send_g, wait_resp, hold_out} fetch_state_t;

	function automatic var_t node_var(node_word_t w);
		return w[2*edge_w +: var_w];
	endfunction

	function automatic edge_t node_high(node_word_t w);
		return w[edge_w +: edge_w];
	endfunction

	function automatic edge_t node_low(node_word_t w);
		return w[0 +: edge_w];
	endfunction

endpackage

`default_nettype wire

// File: rtl/apply_req_if.sv
`timescale 1ns/10ps
`default_nettype none

interface apply_req_if
	import bdd_pkg::*;
();
	logic valid;
	logic ready;
	edge_t f; // Always the smaller index
	edge_t g;
	apply_op_t op;

	modport source (output valid, output f, output g, output op, input ready);

	modport sink (input valid, input f, input g, input op, output ready);

	// Read only view for the datapath next to the FSM
	modport monitor (input valid, input ready, input f, input g, input op);

endinterface

`default_nettype wire

// File: rtl/terminal_case_unit.sv
`timescale 1ns/10ps
`default_nettype none

module terminal_case_unit
	import bdd_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	output logic req_ready,
	input edge_t req_f,
	input edge_t req_g,
	input apply_op_t req_op,
	output logic result_valid,
	input logic result_ready,
	output edge_t result,
	apply_req_if.source fwd
);

	logic full;
	logic held_term; // Item in the register is a terminal result
	edge_t held_f;
	edge_t held_g;
	apply_op_t held_op;
	edge_t held_result;

	edge_t ord_f;
	edge_t ord_g;
	logic term_hit;
	edge_t term_result;
	logic accept;
	logic leave;

	// AND and OR commute so the smaller index always goes first
	assign ord_f = (req_f > req_g) ? req_g : req_f;
	assign ord_g = (req_f > req_g) ? req_f : req_g;

	always_comb
	begin
		term_hit = 1'b1;
		term_result = ord_f;
		if (req_op == op_and)
		begin
			if (ord_f == edge_false || ord_g == edge_false || is_complement(ord_f, ord_g))
				term_result = edge_false;
			else if (ord_f == edge_true)
				term_result = ord_g;
			else if (ord_g == edge_true || ord_f == ord_g)
				term_result = ord_f;
			else
				term_hit = 1'b0;
		end
		else
		begin
			if (ord_f == edge_true || ord_g == edge_true || is_complement(ord_f, ord_g))
				term_result = edge_true;
			else if (ord_f == edge_false)
				term_result = ord_g;
			else if (ord_g == edge_false || ord_f == ord_g)
				term_result = ord_f;
			else
				term_hit = 1'b0;
		end
	end

	assign result_valid = full && held_term;
	assign result = held_result;
	assign fwd.valid = full && !held_term;
	assign fwd.f = held_f;
	assign fwd.g = held_g;
	assign fwd.op = held_op;

	// Item leaves on whichever port it sits on
	assign leave = (result_valid && result_ready) || (fwd.valid && fwd.ready);
	assign req_ready = !full || leave;
	assign accept = req_valid && req_ready;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			full <= 1'b0;
			held_term <= 1'b0;
		end
		else if (accept)
		begin
			full <= 1'b1;
			held_term <= term_hit;
		end
		else if (leave)
			full <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			held_f <= ord_f;
			held_g <= ord_g;
			held_op <= req_op;
			held_result <= term_result;
		end
	end

	result_hold: assert property (@(posedge clk) disable iff (reset)
		result_valid && !result_ready |=> result_valid && $stable(result));

endmodule

`default_nettype wire

// File: rtl/node_fetch_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module node_fetch_fsm
	import fetch_pkg::*;
(
	input logic clk,
	input logic reset,
	apply_req_if.sink item,
	output logic mem_req_valid,
	input logic mem_req_ready,
	output node_addr_t mem_req_addr,
	input logic mem_resp_valid,
	output logic capture_f,
	output logic capture_g,
	output logic expand_valid,
	input logic expand_ready
);

	fetch_state_t state;
	fetch_state_t state_next;
	logic got_f; // First response of the pair is in

	always_comb
	begin
		state_next = state;
		case (state)
			idle:
				if (item.valid)
					state_next = send_f;
			send_f:
				if (mem_req_ready)
					state_next = send_g;
			send_g: // f response may already come back here
				if (mem_req_ready)
					state_next = wait_resp;
			wait_resp:
				if (capture_g)
					state_next = hold_out;
			hold_out:
				if (expand_ready)
					state_next = idle;
			default:
				state_next = idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= idle;
		else
			state <= state_next;
	end

	// Responses come back in order so the first one belongs to f
	always_ff @(posedge clk)
	begin
		if (reset)
			got_f <= 1'b0;
		else if (capture_f)
			got_f <= 1'b1;
		else if (capture_g)
			got_f <= 1'b0;
	end

	assign mem_req_valid = (state == send_f) || (state == send_g);
	assign mem_req_addr = (state == send_g) ? node_addr_t'(item.g >> 1) : node_addr_t'(item.f >> 1);

	assign capture_f = mem_resp_valid && !got_f;
	assign capture_g = mem_resp_valid && got_f;

	assign expand_valid = (state == hold_out);
	assign item.ready = expand_valid && expand_ready; // Pop on the expansion transfer

	mem_req_hold: assert property (@(posedge clk) disable iff (reset)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr));

	// Memory must not answer a read that was never sent
	no_stray_resp: assert property (@(posedge clk) disable iff (reset)
		mem_resp_valid |-> (state == send_g && !got_f) || state == wait_resp);

endmodule

`default_nettype wire

// File: rtl/cofactor_unit.sv
`timescale 1ns/10ps
`default_nettype none

module cofactor_unit
	import bdd_pkg::*;
	import fetch_pkg::*;
(
	input logic clk,
	input logic reset,
	apply_req_if.monitor item,
	input node_word_t mem_resp_data,
	input logic capture_f,
	input logic capture_g,
	output apply_op_t expand_op,
	output var_t expand_top,
	output edge_t expand_f,
	output edge_t expand_g,
	output edge_t fn,
	output edge_t fnv,
	output edge_t gn,
	output edge_t gnv
);

	node_word_t f_node;
	node_word_t g_node;
	var_t f_var;
	var_t g_var;
	var_t top;
	logic f_at_top;
	logic g_at_top;

	always_ff @(posedge clk)
	begin
		if (capture_f)
			f_node <= mem_resp_data;
		if (capture_g)
			g_node <= mem_resp_data;
	end

	assign f_var = node_var(f_node);
	assign g_var = node_var(g_node);
	assign top = (f_var < g_var) ? f_var : g_var;

	assign f_at_top = (f_var == top);
	assign g_at_top = (g_var == top);

	// Children inherit the operand's negation flag
	assign fn = f_at_top ? node_high(f_node) ^ edge_t'(item.f[0]) : item.f;
	assign fnv = f_at_top ? node_low(f_node) ^ edge_t'(item.f[0]) : item.f;
	assign gn = g_at_top ? node_high(g_node) ^ edge_t'(item.g[0]) : item.g;
	assign gnv = g_at_top ? node_low(g_node) ^ edge_t'(item.g[0]) : item.g;

	assign expand_op = item.op;
	assign expand_top = top;
	assign expand_f = item.f;
	assign expand_g = item.g;

	capture_excl: assert property (@(posedge clk) disable iff (reset)
		!(capture_f && capture_g));

endmodule

`default_nettype wire

// File: rtl/apply_top.sv
`timescale 1ns/10ps
`default_nettype none

module apply_top
	import bdd_pkg::*;
	import fetch_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic req_valid,
	output logic req_ready,
	input edge_t req_f,
	input edge_t req_g,
	input apply_op_t req_op,
	output logic result_valid,
	input logic result_ready,
	output edge_t result,
	output logic expand_valid,
	input logic expand_ready,
	output apply_op_t expand_op,
	output var_t expand_top,
	output edge_t expand_f,
	output edge_t expand_g,
	output edge_t fn,
	output edge_t fnv,
	output edge_t gn,
	output edge_t gnv,
	output logic mem_req_valid,
	input logic mem_req_ready,
	output node_addr_t mem_req_addr,
	input logic mem_resp_valid,
	input node_word_t mem_resp_data
);

	logic capture_f;
	logic capture_g;

	apply_req_if req_if ();

	terminal_case_unit terminal_case_unit_i (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_f(req_f),
		.req_g(req_g),
		.req_op(req_op),
		.result_valid(result_valid),
		.result_ready(result_ready),
		.result(result),
		.fwd(req_if.source)
	);

	node_fetch_fsm node_fetch_fsm_i (
		.clk(clk),
		.reset(reset),
		.item(req_if.sink),
		.mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.mem_req_addr(mem_req_addr),
		.mem_resp_valid(mem_resp_valid),
		.capture_f(capture_f),
		.capture_g(capture_g),
		.expand_valid(expand_valid),
		.expand_ready(expand_ready)
	);

	cofactor_unit cofactor_unit_i (
		.clk(clk),
		.reset(reset),
		.item(req_if.monitor),
		.mem_resp_data(mem_resp_data),
		.capture_f(capture_f),
		.capture_g(capture_g),
		.expand_op(expand_op),
		.expand_top(expand_top),
		.expand_f(expand_f),
		.expand_g(expand_g),
		.fn(fn),
		.fnv(fnv),
		.gn(gn),
		.gnv(gnv)
	);

endmodule

`default_nettype wire

// File: testbench/node_memory_model.sv
`timescale 1ns/10ps
`default_nettype none

module node_memory_model
	import bdd_pkg::*;
	import fetch_pkg::*;
#(
	parameter logic [31:0] seed = 32'h1
)
(
	input logic clk,
	input logic reset,
	input logic mem_req_valid,
	output logic mem_req_ready,
	input node_addr_t mem_req_addr,
	output logic mem_resp_valid,
	output node_word_t mem_resp_data
);

	node_word_t node_table [0:7];
	node_word_t resp_words [$]; // Words waiting to be returned, oldest first
	int resp_due [$];

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Each word is {var, high child, low child}
	initial
	begin
		node_table[0] = {8'hff, edge_true, edge_true}; // Terminal, never fetched
		node_table[1] = {8'd5, 16'h0000, 16'h0001};
		node_table[2] = {8'd4, 16'h0002, 16'h0001};
		node_table[3] = {8'd4, 16'h0000, 16'h0003};
		node_table[4] = {8'd2, 16'h0004, 16'h0006};
		node_table[5] = {8'd2, 16'h0007, 16'h0000};
		node_table[6] = {8'd1, 16'h0008, 16'h000a};
		node_table[7] = {8'd3, 16'h0004, 16'h0003};
	end

	initial
	begin
		logic [31:0] rand_state;
		int cycle;
		int last_due;
		int due;
		rand_state = seed;
		cycle = 0;
		last_due = 0;
		mem_req_ready = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_data = '0;
		forever
		begin
			@(negedge clk);
			if (reset)
			begin
				resp_words.delete();
				resp_due.delete();
			end
			else if (mem_req_valid && mem_req_ready)
			begin
				// Request transfers on the next edge, answer 1 to 3 cycles after it
				rand_state = lcg_next(rand_state);
				due = cycle + 1 + int'((rand_state >> 16) % 3);
				if (due <= last_due)
					due = last_due + 1; // Keep responses in order, one per cycle
				last_due = due;
				resp_words.push_back(node_table[mem_req_addr[2:0]]);
				resp_due.push_back(due);
			end
			@(posedge clk);
			cycle++;
			#1;
			rand_state = lcg_next(rand_state);
			mem_req_ready = !reset && (rand_state[31:30] != 2'b00);
			if (resp_due.size() > 0 && resp_due[0] <= cycle)
			begin
				mem_resp_valid = 1'b1;
				mem_resp_data = resp_words.pop_front();
				void'(resp_due.pop_front());
			end
			else
			begin
				mem_resp_valid = 1'b0;
				mem_resp_data = '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/apply_tb.sv
`timescale 1ns/10ps
`default_nettype none

module apply_tb
	import bdd_pkg::*;
	import fetch_pkg::*;
();

	localparam int case_count = 17;
	localparam int cycle_limit = 60 * case_count;
	localparam logic [31:0] seed = 32'hda3a;

	logic clk;
	logic reset;
	logic req_valid;
	logic req_ready;
	edge_t req_f;
	edge_t req_g;
	apply_op_t req_op;
	logic result_valid;
	logic result_ready;
	edge_t result;
	logic expand_valid;
	logic expand_ready;
	apply_op_t expand_op;
	var_t expand_top;
	edge_t expand_f;
	edge_t expand_g;
	edge_t fn;
	edge_t fnv;
	edge_t gn;
	edge_t gnv;
	logic mem_req_valid;
	logic mem_req_ready;
	node_addr_t mem_req_addr;
	logic mem_resp_valid;
	node_word_t mem_resp_data;

	// Stimulus table, one row per request
	apply_op_t op_tab [case_count];
	edge_t f_tab [case_count];
	edge_t g_tab [case_count];
	logic term_tab [case_count];
	edge_t res_tab [case_count]; // Only used by terminal rows

	int case_fill = 0;
	int out_idx = 0; // Next row expected at either output
	int cycle = 0;
	int value_errors = 0;
	int order_errors = 0;

	apply_top apply_top_i (.*);

	node_memory_model #(.seed(seed)) node_memory_i (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic add_case(input apply_op_t op, input edge_t f, input edge_t g,
		input logic term, input edge_t res);
		op_tab[case_fill] = op;
		f_tab[case_fill] = f;
		g_tab[case_fill] = g;
		term_tab[case_fill] = term;
		res_tab[case_fill] = res;
		case_fill++;
	endtask

	task automatic check_value(input string name, input edge_t got, input edge_t want);
		if (got !== want)
		begin
			value_errors++;
			$display("Fail %0t: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	// Expected expansion worked out from the node table
	task automatic check_expansion(input int idx);
		edge_t of;
		edge_t og;
		node_word_t fw;
		node_word_t gw;
		var_t top;
		of = (f_tab[idx] < g_tab[idx]) ? f_tab[idx] : g_tab[idx];
		og = (f_tab[idx] < g_tab[idx]) ? g_tab[idx] : f_tab[idx];
		fw = node_memory_i.node_table[of[3:1]];
		gw = node_memory_i.node_table[og[3:1]];
		top = (fw[39:32] < gw[39:32]) ? fw[39:32] : gw[39:32];
		check_value("expand_op", edge_t'(expand_op), edge_t'(op_tab[idx]));
		check_value("expand_top", edge_t'(expand_top), edge_t'(top));
		check_value("expand_f", expand_f, of);
		check_value("expand_g", expand_g, og);
		check_value("fn", fn, (fw[39:32] == top) ? fw[31:16] ^ {15'b0, of[0]} : of);
		check_value("fnv", fnv, (fw[39:32] == top) ? fw[15:0] ^ {15'b0, of[0]} : of);
		check_value("gn", gn, (gw[39:32] == top) ? gw[31:16] ^ {15'b0, og[0]} : og);
		check_value("gnv", gnv, (gw[39:32] == top) ? gw[15:0] ^ {15'b0, og[0]} : og);
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// Random back-pressure on both outputs
	initial
	begin
		logic [31:0] rand_state;
		rand_state = seed;
		result_ready = 1'b0;
		expand_ready = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			rand_state = lcg_next(rand_state);
			result_ready = rand_state[31:30] != 2'b00;
			expand_ready = rand_state[29:28] != 2'b00;
		end
	end

	initial
	begin
		logic sent;
		reset = 1'b1;
		req_valid = 1'b0;
		req_f = '0;
		req_g = '0;
		req_op = op_and;

		// Terminal rows
		add_case(op_and, 16'h0004, 16'h0001, 1'b1, edge_false);
		add_case(op_and, 16'h0000, 16'h0008, 1'b1, 16'h0008);
		add_case(op_and, 16'h000a, 16'h0000, 1'b1, 16'h000a);
		add_case(op_and, 16'h0006, 16'h0007, 1'b1, edge_false); // Complementary
		add_case(op_and, 16'h000c, 16'h000c, 1'b1, 16'h000c);
		add_case(op_or, 16'h0004, 16'h0000, 1'b1, edge_true);
		add_case(op_or, 16'h0009, 16'h0008, 1'b1, edge_true);
		add_case(op_or, 16'h0001, 16'h000e, 1'b1, 16'h000e);
		// Non-terminal rows mixed with terminal ones
		add_case(op_and, 16'h000a, 16'h0008, 1'b0, '0); // Swapped, equal variables
		add_case(op_or, 16'h0005, 16'h0005, 1'b1, 16'h0005);
		add_case(op_or, 16'h0009, 16'h000b, 1'b0, '0);
		add_case(op_and, 16'h0003, 16'h0008, 1'b0, '0); // Only g at the top
		add_case(op_or, 16'h000e, 16'h0004, 1'b0, '0);
		add_case(op_and, 16'h000c, 16'h0007, 1'b0, '0);
		add_case(op_or, 16'h0002, 16'h0006, 1'b0, '0);
		add_case(op_and, 16'h0004, 16'h0006, 1'b0, '0);
		add_case(op_and, 16'h000f, 16'h000d, 1'b0, '0); // Only f at the top

		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value("req_ready", edge_t'(req_ready), 16'h0001); // Idle after reset
		check_value("result_valid", edge_t'(result_valid), 16'h0000);
		check_value("expand_valid", edge_t'(expand_valid), 16'h0000);
		check_value("mem_req_valid", edge_t'(mem_req_valid), 16'h0000);
		@(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < case_count; i++)
		begin
			req_valid = 1'b1;
			req_f = f_tab[i];
			req_g = g_tab[i];
			req_op = op_tab[i];
			sent = 1'b0;
			while (!sent)
			begin
				@(negedge clk);
				sent = req_ready; // Transfer happens on the coming edge
				@(posedge clk);
				#1;
			end
		end
		req_valid = 1'b0;

		while (out_idx < case_count)
			@(posedge clk);
		repeat (6) @(posedge clk); // Room for a duplicate to show up

		$display("Errors: %0d wrong values, %0d order errors, %0d of %0d outputs seen",
			value_errors, order_errors, out_idx, case_count);
		if (value_errors == 0 && order_errors == 0 && out_idx == case_count)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// Outputs are stable at the falling edge
	always @(negedge clk)
	begin
		if (!reset && result_valid && result_ready)
		begin
			if (out_idx >= case_count || !term_tab[out_idx])
			begin
				order_errors++;
				$display("Terminal result %h came out where none was due at %0t", result, $time);
			end
			else
				check_value("result", result, res_tab[out_idx]);
			out_idx++;
		end
		if (!reset && expand_valid && expand_ready)
		begin
			if (out_idx >= case_count || term_tab[out_idx])
			begin
				order_errors++;
				$display("Expansion of %h and %h came out where none was due at %0t",
					expand_f, expand_g, $time);
			end
			else
				check_expansion(out_idx);
			out_idx++;
		end
	end

	always @(posedge clk)
	begin
		cycle++;
		if (cycle >= cycle_limit)
		begin
			$display("Timed out: %0d wrong values, %0d order errors, %0d of %0d outputs seen",
				value_errors, order_errors, out_idx, case_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: src.f
rtl/bdd_pkg.sv
rtl/fetch_pkg.sv
rtl/apply_req_if.sv
rtl/terminal_case_unit.sv
rtl/node_fetch_fsm.sv
rtl/cofactor_unit.sv
rtl/apply_top.sv
testbench/node_memory_model.sv
testbench/apply_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= apply_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
